//--- rtl/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

    // Register address, register number times eight
    typedef logic [7:0]  cp0_addr_t;
    typedef logic [31:0] cp0_word_t;
    typedef logic [4:0]  exc_code_t;

    // Register map
    localparam cp0_addr_t addr_badvaddr = 8'h40;  // Reg 8
    localparam cp0_addr_t addr_count    = 8'h48;  // Reg 9
    localparam cp0_addr_t addr_compare  = 8'h58;  // Reg 11
    localparam cp0_addr_t addr_status   = 8'h60;  // Reg 12
    localparam cp0_addr_t addr_cause    = 8'h68;  // Reg 13
    localparam cp0_addr_t addr_epc      = 8'h70;  // Reg 14

    // Load address error, the only code that loads BadVAddr
    localparam exc_code_t exc_adel = 5'd4;

    // Requester or fabric side of the register bus
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        cp0_addr_t paddr;
        cp0_word_t pwdata;
    } apb_req_t;

    // Completer side of the register bus
    typedef struct packed {
        logic      pready;
        cp0_word_t prdata;
        logic      pslverr;
    } apb_rsp_t;

    // Exception record from the memory stage
    typedef struct packed {
        logic      exc;       // Exception taken this cycle
        logic      eret;      // Eret taken this cycle
        logic      bd;        // Instruction sits in a delay slot
        exc_code_t code;
        cp0_word_t badvaddr;
        cp0_word_t pc;
    } exc_info_t;

    // Downstream phase of the fabric
    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } fabric_state_t;

endpackage

`default_nettype wire

//--- rtl/cp0_bus_fabric.sv
`default_nettype none

module cp0_bus_fabric (
    input  wire               clk,
    input  wire               rst,
    input  wire cp0_pkg::apb_req_t core_req,
    input  wire cp0_pkg::apb_req_t dbg_req,
    output cp0_pkg::apb_rsp_t core_rsp,
    output cp0_pkg::apb_rsp_t dbg_rsp,
    output cp0_pkg::apb_req_t status_req,
    output cp0_pkg::apb_req_t timer_req,
    input  wire cp0_pkg::apb_rsp_t status_rsp,
    input  wire cp0_pkg::apb_rsp_t timer_rsp
);

    cp0_pkg::fabric_state_t state_q;
    cp0_pkg::apb_req_t      req_q;        // Request of the granted port
    cp0_pkg::apb_rsp_t      bus_rsp;      // Response of the decoded target
    logic                   grant_dbg_q;  // 1 when the debug port holds the grant
    logic                   last_dbg_q;   // Winner of the previous arbitration
    logic                   core_pend;
    logic                   dbg_pend;
    logic                   pick_dbg;
    logic                   accept;
    logic                   in_access;
    logic                   sel_status;
    logic                   sel_timer;

    // A port is pending while in setup or access without the grant
    assign core_pend = core_req.psel && !(state_q != cp0_pkg::idle && !grant_dbg_q);
    assign dbg_pend  = dbg_req.psel && !(state_q != cp0_pkg::idle && grant_dbg_q);

    // Round robin on a tie, otherwise whoever asks
    assign pick_dbg  = dbg_pend && (!core_pend || !last_dbg_q);
    assign accept    = (state_q == cp0_pkg::idle) && (core_pend || dbg_pend);
    assign in_access = (state_q == cp0_pkg::access);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= cp0_pkg::idle;
            grant_dbg_q <= 1'b0;
            last_dbg_q  <= 1'b1;  // Core wins the first tie
        end else begin
            case (state_q)
                cp0_pkg::idle: begin
                    if (accept) begin
                        state_q     <= cp0_pkg::setup;
                        grant_dbg_q <= pick_dbg;
                        last_dbg_q  <= pick_dbg;
                    end
                end
                cp0_pkg::setup: state_q <= cp0_pkg::access;
                cp0_pkg::access: begin
                    if (bus_rsp.pready) begin
                        state_q <= cp0_pkg::idle;
                    end
                end
                default: state_q <= cp0_pkg::idle;
            endcase
        end
    end

    // Captured once at the grant
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= pick_dbg ? dbg_req : core_req;
        end
    end

    // Fixed two-slave address map
    always_comb begin
        sel_status = 1'b0;
        sel_timer  = 1'b0;
        case (req_q.paddr)
            cp0_pkg::addr_badvaddr,
            cp0_pkg::addr_status,
            cp0_pkg::addr_cause,
            cp0_pkg::addr_epc:     sel_status = 1'b1;
            cp0_pkg::addr_count,
            cp0_pkg::addr_compare: sel_timer = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        status_req         = req_q;
        status_req.psel    = (state_q != cp0_pkg::idle) && sel_status;
        status_req.penable = in_access && sel_status;
        timer_req          = req_q;
        timer_req.psel     = (state_q != cp0_pkg::idle) && sel_timer;
        timer_req.penable  = in_access && sel_timer;
    end

    always_comb begin
        if (sel_status) begin
            bus_rsp = status_rsp;
        end else if (sel_timer) begin
            bus_rsp = timer_rsp;
        end else begin
            bus_rsp.pready  = 1'b1;  // Unmapped address ends with an error
            bus_rsp.prdata  = '0;
            bus_rsp.pslverr = 1'b1;
        end
    end

    // Only the granted port sees the response
    assign core_rsp = (in_access && !grant_dbg_q) ? bus_rsp : '0;
    assign dbg_rsp  = (in_access && grant_dbg_q) ? bus_rsp : '0;

endmodule

`default_nettype wire

//--- rtl/cp0_status_regs.sv
`default_nettype none

module cp0_status_regs (
    input  wire                         clk,
    input  wire                         rst,
    input  wire cp0_pkg::apb_req_t      bus_req,
    output cp0_pkg::apb_rsp_t           bus_rsp,
    input  wire cp0_pkg::exc_info_t     exc_in,
    input  wire [5:0]                   ext_int,
    input  wire                         timer_flag,
    output cp0_pkg::cp0_word_t          epc,
    output logic                        interrupt
);

    // Status fields
    logic [7:0]         status_im;
    logic               status_exl;
    logic               status_ie;

    // Cause fields
    logic               cause_bd;
    logic [5:0]         cause_ip_hw;   // IP7..IP2
    logic [1:0]         cause_ip_sw;   // IP1..IP0
    cp0_pkg::exc_code_t cause_exc;

    cp0_pkg::cp0_word_t epc_q;
    cp0_pkg::cp0_word_t badvaddr_q;
    cp0_pkg::cp0_word_t status_word;
    cp0_pkg::cp0_word_t cause_word;

    logic               bus_wr;
    logic               wr_status;
    logic               wr_cause;
    logic               wr_epc;
    logic               first_exc;     // Exception taken with EXL still clear
    logic               hit;

    assign bus_wr    = bus_req.psel && bus_req.penable && bus_req.pwrite;
    assign wr_status = bus_wr && (bus_req.paddr == cp0_pkg::addr_status);
    assign wr_cause  = bus_wr && (bus_req.paddr == cp0_pkg::addr_cause);
    assign wr_epc    = bus_wr && (bus_req.paddr == cp0_pkg::addr_epc);
    assign first_exc = exc_in.exc && !status_exl;

    // BEV is hardwired to one
    assign status_word = {9'b0, 1'b1, 6'b0, status_im, 6'b0, status_exl, status_ie};

    // TI reads the timer flag directly
    assign cause_word = {cause_bd, timer_flag, 14'b0, cause_ip_hw, cause_ip_sw,
                         1'b0, cause_exc, 2'b0};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status_im <= '0;
            status_ie <= 1'b0;
        end else if (wr_status) begin
            status_im <= bus_req.pwdata[15:8];
            status_ie <= bus_req.pwdata[0];
        end
    end

    // Exception over eret over bus write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status_exl <= 1'b0;
        end else if (exc_in.exc) begin
            status_exl <= 1'b1;
        end else if (exc_in.eret) begin
            status_exl <= 1'b0;
        end else if (wr_status) begin
            status_exl <= bus_req.pwdata[1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cause_bd <= 1'b0;
        end else if (first_exc) begin
            cause_bd <= exc_in.bd;  // Nested exceptions keep the first BD
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cause_exc <= '0;
        end else if (exc_in.exc) begin
            cause_exc <= exc_in.code;
        end
    end

    // Hardware lines lag ext_int by one cycle, IP7 shared with the timer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cause_ip_hw <= '0;
        end else begin
            cause_ip_hw <= {ext_int[5] | timer_flag, ext_int[4:0]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cause_ip_sw <= '0;
        end else if (wr_cause) begin
            cause_ip_sw <= bus_req.pwdata[9:8];  // Software interrupts only
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            epc_q <= '0;
        end else if (first_exc) begin
            // Restart at the branch when the faulting instruction is in its slot
            epc_q <= exc_in.bd ? exc_in.pc - 32'd4 : exc_in.pc;
        end else if (wr_epc) begin
            epc_q <= bus_req.pwdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            badvaddr_q <= '0;
        end else if (exc_in.exc && (exc_in.code == cp0_pkg::exc_adel)) begin
            badvaddr_q <= exc_in.badvaddr;
        end
    end

    // Zero-wait read port
    always_comb begin
        hit            = 1'b1;
        bus_rsp.prdata = '0;
        case (bus_req.paddr)
            cp0_pkg::addr_badvaddr: bus_rsp.prdata = badvaddr_q;
            cp0_pkg::addr_status:   bus_rsp.prdata = status_word;
            cp0_pkg::addr_cause:    bus_rsp.prdata = cause_word;
            cp0_pkg::addr_epc:      bus_rsp.prdata = epc_q;
            default:                hit = 1'b0;
        endcase
        bus_rsp.pready  = 1'b1;
        bus_rsp.pslverr = bus_req.psel && !hit;
    end

    assign epc = epc_q;

    // Pending and enabled, globally on, not in exception level
    assign interrupt = (|({cause_ip_hw, cause_ip_sw} & status_im)) && status_ie && !status_exl;

endmodule

`default_nettype wire

//--- rtl/cp0_timer.sv
`default_nettype none

module cp0_timer #(
    parameter int unsigned count_div = 2  // Clocks per Count increment
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire cp0_pkg::apb_req_t bus_req,
    output cp0_pkg::apb_rsp_t      bus_rsp,
    output logic                   timer_flag
);

    localparam int unsigned pre_w = (count_div > 1) ? $clog2(count_div) : 1;

    logic [pre_w-1:0]   pre_q;      // Prescaler phase
    logic               tick;
    cp0_pkg::cp0_word_t count_q;
    cp0_pkg::cp0_word_t compare_q;
    logic               bus_wr;
    logic               wr_count;
    logic               wr_compare;
    logic               hit;

    assign bus_wr     = bus_req.psel && bus_req.penable && bus_req.pwrite;
    assign wr_count   = bus_wr && (bus_req.paddr == cp0_pkg::addr_count);
    assign wr_compare = bus_wr && (bus_req.paddr == cp0_pkg::addr_compare);
    assign tick       = (pre_q == pre_w'(count_div - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pre_q <= '0;
        end else if (tick) begin
            pre_q <= '0;
        end else begin
            pre_q <= pre_q + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q <= '0;
        end else if (wr_count) begin
            count_q <= bus_req.pwdata;  // Load wins over the increment
        end else if (tick) begin
            count_q <= count_q + 32'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            compare_q <= '1;
        end else if (wr_compare) begin
            compare_q <= bus_req.pwdata;
        end
    end

    // Sticky until Compare is written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            timer_flag <= 1'b0;
        end else if (wr_compare) begin
            timer_flag <= 1'b0;
        end else if (count_q == compare_q) begin
            timer_flag <= 1'b1;
        end
    end

    always_comb begin
        hit            = 1'b1;
        bus_rsp.prdata = '0;
        case (bus_req.paddr)
            cp0_pkg::addr_count:   bus_rsp.prdata = count_q;
            cp0_pkg::addr_compare: bus_rsp.prdata = compare_q;
            default:               hit = 1'b0;
        endcase
        bus_rsp.pready  = 1'b1;
        bus_rsp.pslverr = bus_req.psel && !hit;
    end

endmodule

`default_nettype wire

//--- rtl/cp0_top.sv
`default_nettype none

module cp0_top #(
    parameter int unsigned count_div = 2
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire cp0_pkg::apb_req_t  core_req,    // Pipeline MTC0/MFC0 port
    input  wire cp0_pkg::apb_req_t  dbg_req,
    output cp0_pkg::apb_rsp_t       core_rsp,
    output cp0_pkg::apb_rsp_t       dbg_rsp,
    input  wire cp0_pkg::exc_info_t exc_in,      // Memory-stage exception record
    input  wire [5:0]               ext_int,
    output cp0_pkg::cp0_word_t      epc,
    output logic                    interrupt
);

    cp0_pkg::apb_req_t status_req;
    cp0_pkg::apb_rsp_t status_rsp;
    cp0_pkg::apb_req_t timer_req;
    cp0_pkg::apb_rsp_t timer_rsp;
    logic              timer_flag;  // Count matched Compare

    cp0_bus_fabric cp0_bus_fabric_inst (
        .clk        (clk),
        .rst        (rst),
        .core_req   (core_req),
        .dbg_req    (dbg_req),
        .core_rsp   (core_rsp),
        .dbg_rsp    (dbg_rsp),
        .status_req (status_req),
        .timer_req  (timer_req),
        .status_rsp (status_rsp),
        .timer_rsp  (timer_rsp)
    );

    cp0_status_regs cp0_status_regs_inst (
        .clk        (clk),
        .rst        (rst),
        .bus_req    (status_req),
        .bus_rsp    (status_rsp),
        .exc_in     (exc_in),
        .ext_int    (ext_int),
        .timer_flag (timer_flag),
        .epc        (epc),
        .interrupt  (interrupt)
    );

    cp0_timer #(
        .count_div (count_div)
    ) cp0_timer_inst (
        .clk        (clk),
        .rst        (rst),
        .bus_req    (timer_req),
        .bus_rsp    (timer_rsp),
        .timer_flag (timer_flag)
    );

endmodule

`default_nettype wire

//--- tests/cp0_tb.sv
`default_nettype none

module cp0_tb;

    localparam logic [1:0] on_core = 2'd0;
    localparam logic [1:0] on_dbg  = 2'd1;
    localparam logic [1:0] on_both = 2'd2;  // Core runs op_a, debug runs op_b
    localparam logic       rd      = 1'b0;
    localparam logic       wr      = 1'b1;

    typedef struct packed {
        logic               wr;
        cp0_pkg::cp0_addr_t addr;
        cp0_pkg::cp0_word_t data;   // Write data, or expected read data
        cp0_pkg::cp0_word_t mask;   // Read bits that are compared
        logic               err;
        logic [3:0]         lat;    // Cycles from setup to pready
    } op_t;

    typedef struct packed {
        logic [1:0]         port;
        op_t                op_a;
        op_t                op_b;
        cp0_pkg::exc_info_t exc;    // Applied for one cycle before the transfer
        logic [5:0]         ext;
        logic               exp_int;
        logic               chk_int;
        logic               wait_int;
        logic               nondec; // Count read, must not drop below the last one
    } step_t;

    logic               clk;
    logic               rst;
    cp0_pkg::apb_req_t  core_req;
    cp0_pkg::apb_req_t  dbg_req;
    cp0_pkg::apb_rsp_t  core_rsp;
    cp0_pkg::apb_rsp_t  dbg_rsp;
    cp0_pkg::exc_info_t exc_in;
    logic [5:0]         ext_int;
    cp0_pkg::cp0_word_t epc;
    logic               interrupt;

    step_t              steps[$];
    logic [5:0]         cur_ext;
    logic               last_dbg;    // Port of the most recent grant
    int                 seed;
    int                 check_errs;
    int                 timeouts;
    cp0_pkg::cp0_word_t last_count;
    logic               have_count;  // A Count read is already recorded

    cp0_top #(
        .count_div (2)
    ) cp0_top_inst (
        .clk       (clk),
        .rst       (rst),
        .core_req  (core_req),
        .dbg_req   (dbg_req),
        .core_rsp  (core_rsp),
        .dbg_rsp   (dbg_rsp),
        .exc_in    (exc_in),
        .ext_int   (ext_int),
        .epc       (epc),
        .interrupt (interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_word(input string name, input cp0_pkg::cp0_word_t got,
                              input cp0_pkg::cp0_word_t exp, input cp0_pkg::cp0_word_t mask);
        assert ((got & mask) === (exp & mask)) else begin
            check_errs++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name,
                     exp & mask, got & mask);
        end
    endtask

    task automatic drive_port(input logic use_dbg, input cp0_pkg::apb_req_t req);
        if (use_dbg) begin
            dbg_req = req;
        end else begin
            core_req = req;
        end
    endtask

    // Setup now, access from the next falling edge until pready
    task automatic bus_xfer(input logic use_dbg, input op_t op,
                            output cp0_pkg::apb_rsp_t rsp, output int lat);
        cp0_pkg::apb_req_t req;
        req         = '0;
        req.psel    = 1'b1;
        req.pwrite  = op.wr;
        req.paddr   = op.addr;
        req.pwdata  = op.wr ? op.data : '0;
        drive_port(use_dbg, req);
        rsp = '0;
        lat = 0;
        while (!rsp.pready && lat < 20) begin
            @(negedge clk);
            lat++;
            req.penable = 1'b1;
            drive_port(use_dbg, req);
            rsp = use_dbg ? dbg_rsp : core_rsp;
        end
        if (!rsp.pready) begin
            timeouts++;
            $display("Timeout: no pready within 20 cycles for a transfer to address %h", op.addr);
        end
        @(negedge clk);
        drive_port(use_dbg, '0);
    endtask

    task automatic check_op(input int idx, input string port, input op_t op,
                            input cp0_pkg::apb_rsp_t rsp, input int lat);
        if (!op.wr && op.mask != '0) begin
            check_word($sformatf("step %0d %s prdata", idx, port), rsp.prdata, op.data, op.mask);
        end
        check_word($sformatf("step %0d %s pslverr", idx, port), 32'(rsp.pslverr),
                   32'(op.err), '1);
        check_word($sformatf("step %0d %s latency", idx, port), lat, 32'(op.lat), '1);
    endtask

    task automatic run_step(input int idx, input step_t st);
        cp0_pkg::apb_rsp_t rsp_a;
        cp0_pkg::apb_rsp_t rsp_b;
        int                lat_a;
        int                lat_b;
        int                n;
        string             name_a;
        name_a  = (st.port == on_dbg) ? "dbg" : "core";
        ext_int = st.ext;
        if (st.exc.exc || st.exc.eret) begin
            exc_in = st.exc;
            @(negedge clk);
            exc_in = '0;
        end
        if (st.wait_int) begin
            n = 0;
            while (!interrupt && n < 200) begin
                @(negedge clk);
                n++;
            end
            if (!interrupt) begin
                timeouts++;
                $display("Timeout: step %0d saw no interrupt within 200 cycles", idx);
            end
        end
        if (st.port == on_both) begin
            fork
                bus_xfer(1'b0, st.op_a, rsp_a, lat_a);
                bus_xfer(1'b1, st.op_b, rsp_b, lat_b);
            join
            check_op(idx, "dbg", st.op_b, rsp_b, lat_b);
        end else begin
            bus_xfer(st.port == on_dbg, st.op_a, rsp_a, lat_a);
        end
        check_op(idx, name_a, st.op_a, rsp_a, lat_a);
        if (!st.op_a.wr && st.op_a.addr == cp0_pkg::addr_epc) begin
            check_word($sformatf("step %0d epc", idx), epc, st.op_a.data, st.op_a.mask);
        end
        if (st.nondec) begin
            if (have_count) begin
                assert (rsp_a.prdata >= last_count) else begin
                    check_errs++;
                    $display("CHECK FAILED at %0t: step %0d count expected at least %h got %h",
                             $time, idx, last_count, rsp_a.prdata);
                end
            end
            have_count = 1'b1;
            last_count = rsp_a.prdata;
        end
        if (st.chk_int) begin
            check_word($sformatf("step %0d interrupt", idx), 32'(interrupt),
                       32'(st.exp_int), '1);
        end
    endtask

    function automatic step_t xfer(logic [1:0] port, logic write, cp0_pkg::cp0_addr_t addr,
                                   cp0_pkg::cp0_word_t data, cp0_pkg::cp0_word_t mask,
                                   logic exp_int);
        step_t st;
        st           = '0;
        st.port      = port;
        st.op_a.wr   = write;
        st.op_a.addr = addr;
        st.op_a.data = data;
        st.op_a.mask = mask;
        st.ext       = cur_ext;
        st.exp_int   = exp_int;
        st.chk_int   = 1'b1;
        return st;
    endfunction

    function automatic cp0_pkg::exc_info_t exc_rec(logic eret, logic bd,
                                                   cp0_pkg::exc_code_t code,
                                                   cp0_pkg::cp0_word_t va,
                                                   cp0_pkg::cp0_word_t pc);
        cp0_pkg::exc_info_t rec;
        rec.exc      = ~eret;
        rec.eret     = eret;
        rec.bd       = bd;
        rec.code     = code;
        rec.badvaddr = va;
        rec.pc       = pc;
        return rec;
    endfunction

    // Expected latency follows the round robin, the loser waits one more transfer
    function automatic void add_step(step_t st);
        if (st.port == on_both) begin
            st.op_a.lat = last_dbg ? 4'd2 : 4'd5;
            st.op_b.lat = last_dbg ? 4'd5 : 4'd2;
        end else begin
            st.op_a.lat = 4'd2;
            last_dbg    = (st.port == on_dbg);
        end
        steps.push_back(st);
    endfunction

    initial begin
        step_t              st;
        step_t              other;
        cp0_pkg::cp0_word_t pc [3];
        cp0_pkg::cp0_word_t va [3];
        cp0_pkg::cp0_word_t dat [3];
        cp0_pkg::cp0_word_t second;
        int                 i;

        seed       = 32'h0f5b_df43;
        check_errs = 0;
        timeouts   = 0;
        last_count = '0;
        have_count = 1'b0;
        last_dbg   = 1'b0;
        cur_ext    = '0;
        rst        = 1'b1;
        core_req   = '0;
        dbg_req    = '0;
        exc_in     = '0;
        ext_int    = '0;
        for (i = 0; i < 3; i++) begin
            pc[i]  = $random(seed) & 32'hffff_fffc;  // Word aligned
            va[i]  = $random(seed);
            dat[i] = $random(seed);
        end

        // Reset values and write masks
        add_step(xfer(on_core, rd, cp0_pkg::addr_status, 32'h0040_0000, '1, 1'b0));
        add_step(xfer(on_core, rd, cp0_pkg::addr_cause, '0, '1, 1'b0));
        add_step(xfer(on_core, rd, cp0_pkg::addr_epc, '0, '1, 1'b0));
        add_step(xfer(on_core, rd, cp0_pkg::addr_badvaddr, '0, '1, 1'b0));
        add_step(xfer(on_dbg, rd, cp0_pkg::addr_compare, '1, '1, 1'b0));
        add_step(xfer(on_core, wr, cp0_pkg::addr_status, '1, '0, 1'b0));  // EXL blocks it
        add_step(xfer(on_core, rd, cp0_pkg::addr_status, 32'h0040_ff03, '1, 1'b0));
        add_step(xfer(on_core, wr, cp0_pkg::addr_cause, '1, '0, 1'b0));
        add_step(xfer(on_core, rd, cp0_pkg::addr_cause, 32'h0000_0300, '1, 1'b0));
        add_step(xfer(on_dbg, wr, cp0_pkg::addr_epc, 32'h1234_5678, '0, 1'b0));
        add_step(xfer(on_core, rd, cp0_pkg::addr_epc, 32'h1234_5678, '1, 1'b0));
        add_step(xfer(on_core, wr, cp0_pkg::addr_badvaddr, '1, '0, 1'b0));
        add_step(xfer(on_core, rd, cp0_pkg::addr_badvaddr, '0, '1, 1'b0));
        st = xfer(on_core, rd, 8'h08, '0, '1, 1'b0);
        st.op_a.err = 1'b1;
        add_step(st);
        st = xfer(on_dbg, wr, 8'h50, '1, '0, 1'b0);
        st.op_a.err = 1'b1;
        add_step(st);
        add_step(xfer(on_core, wr, cp0_pkg::addr_status, '0, '0, 1'b0));

        // Exception recording
        st = xfer(on_core, rd, cp0_pkg::addr_epc, pc[0], '1, 1'b0);
        st.exc = exc_rec(1'b0, 1'b0, cp0_pkg::exc_adel, va[0], pc[0]);
        add_step(st);
        add_step(xfer(on_core, rd, cp0_pkg::addr_badvaddr, va[0], '1, 1'b0));
        add_step(xfer(on_core, rd, cp0_pkg::addr_cause, 32'h0000_0310, '1, 1'b0));  // Code 4
        add_step(xfer(on_core, rd, cp0_pkg::addr_status, 32'h0040_0002, '1, 1'b0));
        st = xfer(on_core, rd, cp0_pkg::addr_epc, pc[0], '1, 1'b0);  // Nested exception keeps EPC
        st.exc = exc_rec(1'b0, 1'b1, 5'd12, va[1], pc[1]);
        add_step(st);
        add_step(xfer(on_core, rd, cp0_pkg::addr_cause, 32'h0000_0330, '1, 1'b0));
        add_step(xfer(on_core, rd, cp0_pkg::addr_badvaddr, va[0], '1, 1'b0));
        st = xfer(on_core, rd, cp0_pkg::addr_status, 32'h0040_0000, '1, 1'b0);
        st.exc = exc_rec(1'b1, 1'b0, 5'd0, '0, '0);
        add_step(st);
        st = xfer(on_dbg, rd, cp0_pkg::addr_epc, pc[2] - 32'd4, '1, 1'b0);  // Delay slot
        st.exc = exc_rec(1'b0, 1'b1, 5'd10, va[2], pc[2]);
        add_step(st);
        add_step(xfer(on_core, rd, cp0_pkg::addr_cause, 32'h8000_0328, '1, 1'b0));
        add_step(xfer(on_core, rd, cp0_pkg::addr_badvaddr, va[0], '1, 1'b0));
        st = xfer(on_core, rd, cp0_pkg::addr_status, 32'h0040_0000, '1, 1'b0);
        st.exc = exc_rec(1'b1, 1'b0, 5'd0, '0, '0);
        add_step(st);

        // Interrupt gating on software IP0, then on hardware IP4
        add_step(xfer(on_core, wr, cp0_pkg::addr_cause, 32'h0000_0100, '0, 1'b0));
        add_step(xfer(on_core, wr, cp0_pkg::addr_status, 32'h0000_0100, '0, 1'b0));
        add_step(xfer(on_core, wr, cp0_pkg::addr_status, 32'h0000_0101, '0, 1'b1));
        add_step(xfer(on_core, wr, cp0_pkg::addr_status, 32'h0000_0103, '0, 1'b0));
        add_step(xfer(on_core, wr, cp0_pkg::addr_status, 32'h0000_0201, '0, 1'b0));
        add_step(xfer(on_core, wr, cp0_pkg::addr_cause, '0, '0, 1'b0));
        cur_ext = 6'b000100;
        add_step(xfer(on_core, rd, cp0_pkg::addr_cause, 32'h0000_1000, 32'h0000_ff00, 1'b0));
        add_step(xfer(on_core, wr, cp0_pkg::addr_status, 32'h0000_1001, '0, 1'b1));
        cur_ext = '0;
        add_step(xfer(on_core, rd, cp0_pkg::addr_status, 32'h0040_1001, '1, 1'b0));

        // Timer
        st = xfer(on_dbg, rd, cp0_pkg::addr_count, '0, '0, 1'b0);
        st.nondec = 1'b1;
        add_step(st);
        st = xfer(on_core, rd, cp0_pkg::addr_count, '0, '0, 1'b0);
        st.nondec = 1'b1;
        add_step(st);
        add_step(xfer(on_dbg, wr, cp0_pkg::addr_count, 32'h0000_0100, '0, 1'b0));
        add_step(xfer(on_core, wr, cp0_pkg::addr_status, 32'h0000_8001, '0, 1'b0));
        add_step(xfer(on_dbg, wr, cp0_pkg::addr_compare, 32'h0000_0108, '0, 1'b0));
        st = xfer(on_core, rd, cp0_pkg::addr_cause, 32'h4000_8000, 32'h4000_8000, 1'b1);
        st.wait_int = 1'b1;
        add_step(st);
        st = xfer(on_dbg, wr, cp0_pkg::addr_compare, 32'hffff_0000, '0, 1'b0);
        st.chk_int = 1'b0;
        add_step(st);
        add_step(xfer(on_core, rd, cp0_pkg::addr_cause, '0, 32'h4000_8000, 1'b0));

        // Both ports at once, to different slaves and then to one register
        st = xfer(on_both, wr, cp0_pkg::addr_epc, dat[0], '0, 1'b0);
        other = xfer(on_dbg, wr, cp0_pkg::addr_compare, 32'h7fff_0000, '0, 1'b0);
        st.op_b = other.op_a;
        add_step(st);
        st = xfer(on_both, rd, cp0_pkg::addr_epc, dat[0], '1, 1'b0);
        other = xfer(on_dbg, rd, cp0_pkg::addr_compare, 32'h7fff_0000, '1, 1'b0);
        st.op_b = other.op_a;
        add_step(st);
        second = last_dbg ? dat[2] : dat[1];  // Last winner loses the tie
        st = xfer(on_both, wr, cp0_pkg::addr_epc, dat[1], '0, 1'b0);
        other = xfer(on_dbg, wr, cp0_pkg::addr_epc, dat[2], '0, 1'b0);
        st.op_b = other.op_a;
        add_step(st);
        add_step(xfer(on_core, rd, cp0_pkg::addr_epc, second, '1, 1'b0));

        repeat (5) @(negedge clk);
        rst = 1'b0;
        foreach (steps[k]) begin
            run_step(k, steps[k]);
        end

        $display("Errors: %0d failed checks, %0d timeouts", check_errs, timeouts);
        if (check_errs == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
rtl/cp0_pkg.sv
rtl/cp0_bus_fabric.sv
rtl/cp0_status_regs.sv
rtl/cp0_timer.sv
rtl/cp0_top.sv
tests/cp0_tb.sv

//--- run_sim.sh
#!/bin/sh

log=sim.log

verilator --binary --timing --assert --top-module cp0_tb -f tb.f -o cp0_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cp0_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation failed" "$log"; then
    exit 1
fi
exit 0
